// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuTb
FILELIST = sim.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim.f ====
source/cpuPkg.sv
source/ctrlIf.sv
source/instrMem.sv
source/controlUnit.sv
source/regFile.sv
source/aluSlice.sv
source/alu.sv
source/dataMem.sv
source/cpuTop.sv
tests/tbClock.sv
tests/cpuTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpT op,
    output wordT  result,
    output logic  zero,
    output logic  overflow
);

    logic [numSlices-1:0] sliceGen;
    logic [numSlices-1:0] sliceProp;
    logic [numSlices-1:0] sliceCin;    // From block lookahead
    logic [numSlices-1:0] sliceCout;
    logic [numSlices-1:0] sliceMsbCin;
    logic                 subMode;     // Carry-in one for sub and slt
    logic                 sltSet;      // a < b, signed

    assign subMode = op[2];

    // Block lookahead over slice group terms, no ripple between slices
    always_comb begin
        logic genAcc;
        logic runP;
        sliceCin[0] = subMode;
        for (int k = 1; k < numSlices; k++) begin
            genAcc = 1'b0;
            runP   = 1'b1;
            for (int j = k - 1; j >= 0; j--) begin
                genAcc = genAcc | (runP & sliceGen[j]);
                runP   = runP & sliceProp[j];
            end
            sliceCin[k] = genAcc | (runP & subMode);
        end
    end

    for (genvar k = 0; k < numSlices; k++) begin : genSlice
        aluSlice sliceInst (
            .a          (a[k*sliceWidth +: sliceWidth]),
            .b          (b[k*sliceWidth +: sliceWidth]),
            .cin        (sliceCin[k]),
            .less       ((k == 0) ? sltSet : 1'b0), // Only bit 0 takes the set
            .op         (op),
            .result     (result[k*sliceWidth +: sliceWidth]),
            .cout       (sliceCout[k]),
            .grpGen     (sliceGen[k]),
            .grpProp    (sliceProp[k]),
            .msbCarryIn (sliceMsbCin[k])
        );
    end

    assign overflow = sliceMsbCin[numSlices-1] ^ sliceCout[numSlices-1];

    // Sign of a - b rebuilt from the top bit, flipped on overflow
    assign sltSet = (a[31] ^ ~b[31] ^ sliceMsbCin[numSlices-1]) ^ overflow;

    assign zero = (result == '0);

endmodule

// ==== source/aluSlice.sv ====
`timescale 1ns/1ns

module aluSlice import cpuPkg::*; (
    input  logic [sliceWidth-1:0] a,
    input  logic [sliceWidth-1:0] b,
    input  logic                  cin,        // From block lookahead
    input  logic                  less,       // Set value for slt, bit 0 only
    input  aluOpT                 op,
    output logic [sliceWidth-1:0] result,
    output logic                  cout,
    output logic                  grpGen,     // Slice generates a carry
    output logic                  grpProp,    // Slice passes carry through
    output logic                  msbCarryIn  // Carry into top bit, for overflow
);

    logic [sliceWidth-1:0] bInv; // b, inverted for sub and slt
    logic [sliceWidth-1:0] gen;
    logic [sliceWidth-1:0] prop;
    logic [sliceWidth:0]   carry;
    logic [sliceWidth-1:0] sum;

    assign bInv = op[2] ? ~b : b;
    assign gen  = a & bInv;
    assign prop = a | bInv; // OR form, same carries as XOR form

    // Two-level lookahead, each carry a sum of products of gen and prop
    always_comb begin
        logic genAcc;
        logic runP;
        carry[0] = cin;
        for (int i = 1; i <= sliceWidth; i++) begin
            genAcc = 1'b0;
            runP   = 1'b1;
            for (int j = i - 1; j >= 0; j--) begin
                genAcc = genAcc | (runP & gen[j]);
                runP   = runP & prop[j];
            end
            carry[i] = genAcc | (runP & cin);
        end
    end

    // Full-width generate term without cin
    always_comb begin
        logic runP;
        grpGen = 1'b0;
        runP   = 1'b1;
        for (int j = sliceWidth - 1; j >= 0; j--) begin
            grpGen = grpGen | (runP & gen[j]);
            runP   = runP & prop[j];
        end
    end

    assign grpProp    = &prop;
    assign cout       = carry[sliceWidth];
    assign msbCarryIn = carry[sliceWidth-1];
    assign sum        = a ^ bInv ^ carry[sliceWidth-1:0];

    always_comb begin
        case (op)
            aluAnd:         result = a & bInv;
            aluOr:          result = a | bInv;
            aluAdd, aluSub: result = sum;
            aluSlt:         result = {{(sliceWidth - 1){1'b0}}, less};
            default:        result = '0;
        endcase
    end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit import cpuPkg::*; (
    input  opcodeT opcode,
    input  functT  funct,
    ctrlIf.decoder ctrl
);

    always_comb begin
        ctrl.aluSrc   = 1'b0; // Everything idle unless decoded
        ctrl.regDst   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.beq      = 1'b0;
        ctrl.bne      = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.aluOp    = aluAnd;

        case (opcode)
            opRtype: begin
                case (funct)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.aluOp = aluAnd;
                endcase
                if (funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt}) begin
                    ctrl.regDst   = 1'b1; // Destination in rd
                    ctrl.regWrite = 1'b1; // Unknown funct writes nothing
                end
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1; // Base plus offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = aluSub; // Compare via zero flag
            end
            opBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = aluSub;
            end
            opJ:     ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] wordT;    // Data or byte address
    typedef logic [4:0]  regAddrT; // Register number
    typedef logic [5:0]  opcodeT;  // Instr[31:26]
    typedef logic [5:0]  functT;   // Instr[5:0], R-type only

    // ALU op encoding, bit 2 selects inverted b with carry-in of one
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOpT;

    localparam int imemBytes    = 1024;
    localparam int dmemBytes    = 1024;
    localparam int imemAddrBits = $clog2(imemBytes); // Byte index bits
    localparam int dmemAddrBits = $clog2(dmemBytes);
    localparam int numRegs      = 32;

    localparam int sliceWidth = 4; // Bits per ALU slice
    localparam int numSlices  = 8; // Slices per 32-bit word

    localparam opcodeT opRtype = 6'b000000;
    localparam opcodeT opLw    = 6'b100011;
    localparam opcodeT opSw    = 6'b101011;
    localparam opcodeT opBeq   = 6'b000100;
    localparam opcodeT opBne   = 6'b000101;
    localparam opcodeT opJ     = 6'b000010;
    localparam opcodeT opAddi  = 6'b001000;

    localparam functT fnAdd = 6'b100000;
    localparam functT fnSub = 6'b100010;
    localparam functT fnAnd = 6'b100100;
    localparam functT fnOr  = 6'b100101;
    localparam functT fnSlt = 6'b101010;

endpackage

// ==== source/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  logic    imemWe,   // Program load, held during reset
    input  wordT    imemAddr,
    input  wordT    imemData,
    output wordT    pc,
    output logic    regWe,    // Commit trace from here down
    output regAddrT regWaddr,
    output wordT    regWdata,
    output logic    memWe,
    output wordT    memAddr,
    output wordT    memWdata
);

    wordT    instr;
    wordT    rdataA;
    wordT    rdataB;
    wordT    signExt;
    wordT    aluB;
    wordT    aluResult;
    logic    aluZero;
    wordT    memRdata;
    wordT    pcPlus4;
    wordT    branchTarget;
    wordT    jumpTarget;
    logic    takeBranch;
    wordT    nextPc;
    regAddrT destReg;
    wordT    wbData;

    ctrlIf ctrl0 ();

    instrMem imem0 (.Clk(Clk), .loadEn(imemWe), .loadAddr(imemAddr), .loadData(imemData),
                    .fetchAddr(pc), .instr(instr));

    controlUnit dec0 (.opcode(instr[31:26]), .funct(instr[5:0]), .ctrl(ctrl0));

    assign signExt = {{16{instr[15]}}, instr[15:0]};
    assign destReg = ctrl0.regDst ? instr[15:11] : instr[20:16]; // rd or rt
    assign aluB    = ctrl0.aluSrc ? signExt : rdataB;
    assign wbData  = ctrl0.memToReg ? memRdata : aluResult;

    regFile rf0 (.Clk(Clk), .rstN(rstN), .raddrA(instr[25:21]), .raddrB(instr[20:16]),
                 .waddr(destReg), .wdata(wbData), .we(ctrl0.regWrite),
                 .rdataA(rdataA), .rdataB(rdataB));

    alu alu0 (.a(rdataA), .b(aluB), .op(ctrl0.aluOp), .result(aluResult),
              .zero(aluZero), .overflow());

    // No stores while the program is still loading
    dataMem dmem0 (.Clk(Clk), .addr(aluResult), .wdata(rdataB),
                   .we(ctrl0.memWrite && rstN), .rdata(memRdata));

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExt[29:0], 2'b00}; // Word offset
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign takeBranch   = (ctrl0.beq && aluZero) || (ctrl0.bne && !aluZero);

    always_comb begin
        if (ctrl0.jump) begin
            nextPc = jumpTarget;
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc; // One instruction per edge
        end
    end

    assign regWe    = ctrl0.regWrite;
    assign regWaddr = destReg;
    assign regWdata = wbData;
    assign memWe    = ctrl0.memWrite;
    assign memAddr  = aluResult;
    assign memWdata = rdataB;

endmodule

// ==== source/ctrlIf.sv ====
`timescale 1ns/1ns

interface ctrlIf import cpuPkg::*; ();

    logic  aluSrc;   // Immediate as ALU operand b
    logic  regDst;   // Write rd instead of rt
    logic  memWrite; // Store word
    logic  memToReg; // Writeback from data memory
    logic  regWrite; // Register file write
    logic  beq;      // Branch on zero
    logic  bne;      // Branch on not zero
    logic  jump;     // Absolute jump
    aluOpT aluOp;

    modport decoder (output aluSrc, regDst, memWrite, memToReg, regWrite,
                     beq, bne, jump, aluOp);
    modport datapath (input aluSrc, regDst, memWrite, memToReg, regWrite,
                      beq, bne, jump, aluOp);

endinterface

// ==== source/dataMem.sv ====
`timescale 1ns/1ns

module dataMem import cpuPkg::*; (
    input  logic Clk,
    input  wordT addr,  // ALU result
    input  wordT wdata, // rt value
    input  logic we,
    output wordT rdata
);

    logic [7:0] mem [dmemBytes]; // Byte array, big-endian words

    logic [dmemAddrBits-3:0] wordIdx;

    assign wordIdx = addr[dmemAddrBits-1:2]; // Upper address bits wrap

    assign rdata = {mem[{wordIdx, 2'd0}], mem[{wordIdx, 2'd1}],
                    mem[{wordIdx, 2'd2}], mem[{wordIdx, 2'd3}]};

    always_ff @(posedge Clk) begin
        if (we) begin
            mem[{wordIdx, 2'd0}] <= wdata[31:24];
            mem[{wordIdx, 2'd1}] <= wdata[23:16];
            mem[{wordIdx, 2'd2}] <= wdata[15:8];
            mem[{wordIdx, 2'd3}] <= wdata[7:0];
        end
    end

    // Base plus offset from the ALU has to land on a word boundary
    assert property (@(posedge Clk) we |-> addr[1:0] == 2'b00);

endmodule

// ==== source/instrMem.sv ====
`timescale 1ns/1ns

module instrMem import cpuPkg::*; (
    input  logic Clk,
    input  logic loadEn,    // Program load strobe
    input  wordT loadAddr,
    input  wordT loadData,
    input  wordT fetchAddr, // From pc
    output wordT instr
);

    logic [7:0] mem [imemBytes]; // Byte array, big-endian words

    logic [imemAddrBits-3:0] fetchWord; // Word index of fetch
    logic [imemAddrBits-3:0] loadWord;  // Word index of load

    assign fetchWord = fetchAddr[imemAddrBits-1:2];
    assign loadWord  = loadAddr[imemAddrBits-1:2];

    assign instr = {mem[{fetchWord, 2'd0}], mem[{fetchWord, 2'd1}], // MSB first
                    mem[{fetchWord, 2'd2}], mem[{fetchWord, 2'd3}]};

    always_ff @(posedge Clk) begin
        if (loadEn) begin
            mem[{loadWord, 2'd0}] <= loadData[31:24]; // MSB at lowest byte
            mem[{loadWord, 2'd1}] <= loadData[23:16];
            mem[{loadWord, 2'd2}] <= loadData[15:8];
            mem[{loadWord, 2'd3}] <= loadData[7:0];
        end
    end

    // pc only ever steps by words, branch and jump targets included
    assert property (@(posedge Clk) disable iff ($isunknown(fetchAddr))
                     fetchAddr[1:0] == 2'b00);

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  regAddrT raddrA, // rs
    input  regAddrT raddrB, // rt
    input  regAddrT waddr,
    input  wordT    wdata,
    input  logic    we,
    output wordT    rdataA,
    output wordT    rdataB
);

    wordT regs [numRegs];

    // Register 0 hardwired to zero on read
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // Writes to r0 dropped
            regs[waddr] <= wdata;
        end
    end

    // Destination mux in the top must settle before any write
    assert property (@(posedge Clk) disable iff (!rstN)
                     we |-> !$isunknown(waddr));

endmodule

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();

    localparam int progWords = imemBytes / 4;
    localparam int memWords  = dmemBytes / 4;
    localparam int maxCycles = 200; // Run limit after load

    logic    Clk;
    logic    genRstN;  // Reset from clock module
    logic    loadDone; // Holds reset during load
    logic    dutRstN;
    logic    imemWe;
    wordT    imemAddr;
    wordT    imemData;
    wordT    pc;
    logic    regWe;
    regAddrT regWaddr;
    wordT    regWdata;
    logic    memWe;
    wordT    memAddr;
    wordT    memWdata;

    wordT    prog [progWords]; // Program image, also the model's fetch source
    int      progLen;
    wordT    doneAddr;         // Final self-jump
    integer  seed;
    int      errorCount;
    int      timeoutCount;

    wordT    mPc;              // Model state
    wordT    mRegs [numRegs];
    wordT    mMem [memWords];
    logic    expRegWe;
    regAddrT expWaddr;
    wordT    expWdata;
    logic    expMemWe;
    wordT    expMemAddr;
    wordT    expMemWdata;
    wordT    expNextPc;
    logic    expRedirect;      // Branch taken or jump
    logic    lastValid;        // Previous cycle was a commit
    wordT    lastPc;
    logic    lastRedirect;
    wordT    lastTarget;

    assign dutRstN = genRstN && loadDone;

    tbClock clk0 (.Clk(Clk), .rstN(genRstN));

    cpuTop dut0 (.Clk(Clk), .rstN(dutRstN), .imemWe(imemWe), .imemAddr(imemAddr),
                 .imemData(imemData), .pc(pc), .regWe(regWe), .regWaddr(regWaddr),
                 .regWdata(regWdata), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata));

    function automatic wordT encodeR(regAddrT rs, regAddrT rt, regAddrT rd, functT fn);
        return {opRtype, rs, rt, rd, 5'd0, fn}; // shamt unused
    endfunction

    function automatic wordT encodeI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encodeJ(int wordIdx);
        return {opJ, 26'(wordIdx)}; // Word index within the 256 MB region
    endfunction

    // Expected commit from model state, straight from the ISA rules
    always_comb begin
        wordT ins;
        wordT a;
        wordT b;
        wordT imm;
        wordT ea;
        wordT pc4;
        ins         = prog[mPc[imemAddrBits-1:2]];
        a           = mRegs[ins[25:21]]; // rs
        b           = mRegs[ins[20:16]]; // rt
        imm         = {{16{ins[15]}}, ins[15:0]};
        ea          = a + imm;
        pc4         = mPc + 32'd4;
        expRegWe    = 1'b0;
        expWaddr    = ins[20:16];
        expWdata    = '0;
        expMemWe    = 1'b0;
        expMemAddr  = '0;
        expMemWdata = '0;
        expNextPc   = pc4;
        expRedirect = 1'b0;
        case (ins[31:26])
            opRtype: begin
                expRegWe = 1'b1;
                expWaddr = ins[15:11]; // rd
                case (ins[5:0])
                    fnAdd:   expWdata = a + b;
                    fnSub:   expWdata = a - b;
                    fnAnd:   expWdata = a & b;
                    fnOr:    expWdata = a | b;
                    fnSlt:   expWdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: expRegWe = 1'b0;
                endcase
            end
            opAddi: begin
                expRegWe = 1'b1;
                expWdata = ea;
            end
            opLw: begin
                expRegWe = 1'b1;
                expWdata = mMem[ea[dmemAddrBits-1:2]];
            end
            opSw: begin
                expMemWe    = 1'b1;
                expMemAddr  = ea;
                expMemWdata = b;
            end
            opBeq: expRedirect = (a == b);
            opBne: expRedirect = (a != b);
            opJ: begin
                expRedirect = 1'b1;
                expNextPc   = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
        if (expRedirect && ins[31:26] != opJ) begin
            expNextPc = pc4 + {imm[29:0], 2'b00}; // Word offset from pc plus four
        end
    end

    // Model steps on the same edge the DUT commits
    always @(posedge Clk) begin
        if (!dutRstN) begin
            mPc <= '0;
            for (int i = 0; i < numRegs; i++) begin
                mRegs[i] <= '0;
            end
            lastValid <= 1'b0;
        end else begin
            mPc <= expNextPc;
            if (expRegWe && expWaddr != '0) begin // r0 stays zero
                mRegs[expWaddr] <= expWdata;
            end
            if (expMemWe) begin
                mMem[expMemAddr[dmemAddrBits-1:2]] <= expMemWdata;
            end
            lastValid <= 1'b1;
        end
        lastPc       <= pc;
        lastRedirect <= expRedirect;
        lastTarget   <= expNextPc;
    end

    // First commit after reset is addi into r1
    assert property (@(posedge Clk) $rose(dutRstN) |-> (pc == '0 && regWe && regWaddr == 5'd1))
        else begin
            errorCount++;
            $display("error firstCommit expected pc 0 we 1 waddr 1 actual pc %h we %b waddr %0d",
                     $sampled(pc), $sampled(regWe), $sampled(regWaddr));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN) pc == mPc)
        else begin
            errorCount++;
            $display("error pcTrack expected %h actual %h", $sampled(mPc), $sampled(pc));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN)
                     (lastValid && !lastRedirect) |-> pc == lastPc + 32'd4)
        else begin
            errorCount++;
            $display("error pcStep expected %h actual %h",
                     $sampled(lastPc) + 32'd4, $sampled(pc));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN)
                     (lastValid && lastRedirect) |-> pc == lastTarget)
        else begin
            errorCount++;
            $display("error redirect expected %h actual %h", $sampled(lastTarget), $sampled(pc));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN) regWe == expRegWe)
        else begin
            errorCount++;
            $display("error regWe expected %b actual %b", $sampled(expRegWe), $sampled(regWe));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN)
                     (regWe && expRegWe) |-> (regWaddr == expWaddr && regWdata == expWdata))
        else begin
            errorCount++;
            $display("error regWrite expected r%0d=%h actual r%0d=%h", $sampled(expWaddr),
                     $sampled(expWdata), $sampled(regWaddr), $sampled(regWdata));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN) memWe == expMemWe)
        else begin
            errorCount++;
            $display("error memWe expected %b actual %b", $sampled(expMemWe), $sampled(memWe));
        end

    assert property (@(posedge Clk) disable iff (!dutRstN)
                     (memWe && expMemWe) |-> (memAddr == expMemAddr && memWdata == expMemWdata))
        else begin
            errorCount++;
            $display("error store expected [%h]=%h actual [%h]=%h", $sampled(expMemAddr),
                     $sampled(expMemWdata), $sampled(memAddr), $sampled(memWdata));
        end

    task automatic buildProgram();
        int      k;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        functT   fn;
        k = 0;
        for (int r = 1; r <= 8; r++) begin // Prologue, random 16-bit immediates
            prog[k] = encodeI(opAddi, 5'd0, regAddrT'(r), 16'($random(seed)));
            k++;
        end
        prog[k] = encodeI(opAddi, 5'd0, 5'd9, 16'd16); // r9 is the store base
        k++;
        for (int n = 0; n < 12; n++) begin
            rs = regAddrT'(1 + $unsigned($random(seed)) % 8); // r1 to r8 only
            rt = regAddrT'(1 + $unsigned($random(seed)) % 8);
            rd = regAddrT'(1 + $unsigned($random(seed)) % 8);
            case (n % 5) // Every funct at least twice
                0:       fn = fnAdd;
                1:       fn = fnSub;
                2:       fn = fnAnd;
                3:       fn = fnOr;
                default: fn = fnSlt;
            endcase
            prog[k] = encodeR(rs, rt, rd, fn);
            k++;
        end
        prog[k] = encodeI(opSw, 5'd9, 5'd3, 16'd8);   // Word at 24
        prog[k + 1] = encodeI(opLw, 5'd9, 5'd10, 16'd8);
        prog[k + 2] = encodeI(opBeq, 5'd10, 5'd3, 16'd1); // Taken, same word
        prog[k + 3] = encodeI(opAddi, 5'd0, 5'd11, 16'd1); // Skipped
        prog[k + 4] = encodeI(opBeq, 5'd0, 5'd9, 16'd1);   // Not taken
        prog[k + 5] = encodeI(opAddi, 5'd0, 5'd12, 16'd2);
        prog[k + 6] = encodeI(opBne, 5'd0, 5'd9, 16'd1);   // Taken
        prog[k + 7] = encodeI(opAddi, 5'd0, 5'd11, 16'd3); // Skipped
        prog[k + 8] = encodeJ(k + 10);
        prog[k + 9] = encodeI(opAddi, 5'd0, 5'd11, 16'd4); // Skipped
        prog[k + 10] = encodeJ(k + 10); // Parks the CPU
        doneAddr = wordT'((k + 10) * 4);
        progLen = k + 11;
    endtask

    initial begin
        int cycles;
        seed         = 32'h1a2f_9dce;
        errorCount   = 0;
        timeoutCount = 0;
        loadDone     = 1'b0;
        imemWe       = 1'b0;
        imemAddr     = '0;
        imemData     = '0;
        buildProgram();
        for (int i = 0; i < progLen; i++) begin // One word per cycle
            @(negedge Clk);
            imemWe   = 1'b1;
            imemAddr = wordT'(i * 4);
            imemData = prog[i];
        end
        @(negedge Clk);
        imemWe = 1'b0;
        cycles = 0;
        while (!genRstN && cycles < 10) begin
            @(negedge Clk);
            cycles++;
        end
        if (!genRstN) begin
            timeoutCount++;
            $display("timeout: clock module never released reset");
        end
        loadDone = 1'b1; // CPU starts at pc 0
        cycles   = 0;
        while (pc != doneAddr && cycles < maxCycles) begin
            @(negedge Clk);
            cycles++;
        end
        if (pc != doneAddr) begin
            timeoutCount++;
            $display("timeout: pc never reached the final self-jump");
        end
        repeat (2) @(negedge Clk); // Self-jump commits once more
        $display("Checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/1ns

module tbClock (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk; // 100 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge Clk); // Two cycles of reset
        @(negedge Clk);
        rstN = 1'b1;
    end

endmodule
